// File: umi_pkg.sv
`default_nettype none

package umi_pkg;

   // field positions inside the command word
   localparam int UMI_OPCODE_LSB = 0;
   localparam int UMI_ATOMIC_LSB = 8;
   localparam int UMI_OPCODE_W   = 8;

   // bit 0 set marks a response (device to host)
   typedef enum logic [7:0] {
      UMI_INVALID      = 8'h00,
      UMI_RESP_READ    = 8'h01,
      UMI_REQ_READ     = 8'h02,
      UMI_RESP_WRITE   = 8'h03,
      UMI_REQ_WRITE    = 8'h04,
      UMI_RESP_USER0   = 8'h05,
      UMI_REQ_POSTED   = 8'h06,
      UMI_RESP_USER1   = 8'h07,
      UMI_REQ_RDMA     = 8'h08,
      UMI_RESP_FUTURE0 = 8'h09,
      UMI_REQ_ATOMIC   = 8'h0A,
      UMI_RESP_FUTURE1 = 8'h0B,
      UMI_REQ_USER0    = 8'h0C,
      UMI_RESP_LINK    = 8'h0D,
      UMI_REQ_FUTURE0  = 8'h0E,
      UMI_RESP_ERROR   = 8'h0F
   } umi_opcode_e;

   // atomic type, command bits 15:8
   // values above swap are unknown types
   typedef enum logic [7:0] {
      UMI_ATOMIC_ADD  = 8'h00,
      UMI_ATOMIC_AND  = 8'h01,
      UMI_ATOMIC_OR   = 8'h02,
      UMI_ATOMIC_XOR  = 8'h03,
      UMI_ATOMIC_MAX  = 8'h04,
      UMI_ATOMIC_MIN  = 8'h05,
      UMI_ATOMIC_MAXU = 8'h06,
      UMI_ATOMIC_MINU = 8'h07,
      UMI_ATOMIC_SWAP = 8'h08
   } umi_atomic_e;

endpackage

`default_nettype wire

// File: umi_decode.sv
`timescale 1ns/1ps
`default_nettype none

module umi_decode
   import umi_pkg::*;
#(
   parameter int CW = 32
) (
   input  logic [CW-1:0] command,
   output logic          cmd_invalid,
   output logic          cmd_request,
   output logic          cmd_read,
   output logic          cmd_write,
   output logic          cmd_write_posted,
   output logic          cmd_atomic,
   output logic          cmd_unsupported,
   output umi_atomic_e   atomic_op
);

   umi_opcode_e opcode;
   logic        atomic_known;
   logic        req_atomic;

   // raw fields, unknown encodings pass through the cast unchanged
   assign opcode    = umi_opcode_e'(command[UMI_OPCODE_LSB +: UMI_OPCODE_W]);
   assign atomic_op = umi_atomic_e'(command[UMI_ATOMIC_LSB +: 8]);

   assign cmd_invalid = (opcode == UMI_INVALID);

   // even opcodes are requests, odd ones are responses
   assign cmd_request = ~opcode[0] & ~cmd_invalid;

   // full opcode byte compares, so 0x1x and above never alias
   assign cmd_read         = (opcode == UMI_REQ_READ);
   assign cmd_write_posted = (opcode == UMI_REQ_POSTED);
   assign cmd_write        = (opcode == UMI_REQ_WRITE) | cmd_write_posted;

   // swap is the last defined atomic type
   assign atomic_known = (atomic_op <= UMI_ATOMIC_SWAP);
   assign req_atomic   = (opcode == UMI_REQ_ATOMIC);
   assign cmd_atomic   = req_atomic & atomic_known;

   // rdma, user0, future0, unknown atomics and high even opcodes
   assign cmd_unsupported = cmd_request & ~cmd_read & ~cmd_write & ~cmd_atomic;

endmodule

`default_nettype wire

// File: umi_atomic_alu.sv
`timescale 1ns/1ps
`default_nettype none

module umi_atomic_alu
   import umi_pkg::*;
#(
   parameter int DW = 32
) (
   input  umi_atomic_e   op,
   input  logic [DW-1:0] old_data,
   input  logic [DW-1:0] operand,
   output logic [DW-1:0] new_data
);

   logic signed_gt;
   logic unsigned_gt;

   // old value compared against operand
   assign signed_gt   = $signed(old_data) > $signed(operand);
   assign unsigned_gt = old_data > operand;

   always_comb begin
      case (op)
         UMI_ATOMIC_ADD: begin
            new_data = old_data + operand;
         end
         UMI_ATOMIC_AND: begin
            new_data = old_data & operand;
         end
         UMI_ATOMIC_OR: begin
            new_data = old_data | operand;
         end
         UMI_ATOMIC_XOR: begin
            new_data = old_data ^ operand;
         end
         UMI_ATOMIC_MAX: begin
            new_data = signed_gt ? old_data : operand;
         end
         UMI_ATOMIC_MIN: begin
            new_data = signed_gt ? operand : old_data;
         end
         UMI_ATOMIC_MAXU: begin
            new_data = unsigned_gt ? old_data : operand;
         end
         UMI_ATOMIC_MINU: begin
            new_data = unsigned_gt ? operand : old_data;
         end
         UMI_ATOMIC_SWAP: begin
            new_data = operand;
         end
         default: begin
            // unknown type leaves the word as it was
            new_data = old_data;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: umi_mem_endpoint.sv
`timescale 1ns/1ps
`default_nettype none

module umi_mem_endpoint
   import umi_pkg::*;
#(
   parameter int CW = 32,
   parameter int DW = 32,
   parameter int AW = 6
) (
   input  logic          clk,
   input  logic          rst,
   // request strobe
   input  logic          req_valid,
   input  logic [CW-1:0] req_cmd,
   input  logic [AW-1:0] req_addr,
   input  logic [DW-1:0] req_data,
   // decode flags for req_cmd
   input  logic          cmd_request,
   input  logic          cmd_read,
   input  logic          cmd_write,
   input  logic          cmd_write_posted,
   input  logic          cmd_atomic,
   input  logic          cmd_unsupported,
   input  umi_atomic_e   atomic_op,
   // atomic ALU
   input  logic [DW-1:0] alu_new_data,
   output umi_atomic_e   alu_op,
   output logic [DW-1:0] alu_old_data,
   output logic [DW-1:0] alu_operand,
   // response strobe
   output logic          resp_valid,
   output logic [CW-1:0] resp_cmd,
   output logic [AW-1:0] resp_addr,
   output logic [DW-1:0] resp_data
);

   localparam int DEPTH = 1 << AW;

   logic [DW-1:0] mem [DEPTH];

   // stage 1 registers
   logic          s1_valid;
   logic [CW-1:0] s1_cmd;
   logic [AW-1:0] s1_addr;
   logic [DW-1:0] s1_data;
   logic          s1_read;
   logic          s1_write;
   logic          s1_posted;
   logic          s1_atomic;
   umi_atomic_e   s1_op;

   // stage 2 combinational
   logic [DW-1:0] rd_data;
   logic          wr_en;
   logic [DW-1:0] wr_data;
   logic          rsp_fire;
   umi_opcode_e   rsp_opcode;
   logic [DW-1:0] rsp_data;

   // stage 1, only requests enter, dropped commands vanish here
   always_ff @(posedge clk) begin
      if (rst) begin
         s1_valid <= 1'b0;
      end else begin
         s1_valid <= req_valid & cmd_request;
      end
   end

   always_ff @(posedge clk) begin
      if (req_valid) begin
         s1_cmd    <= req_cmd;
         s1_addr   <= req_addr;
         s1_data   <= req_data;
         s1_read   <= cmd_read;
         s1_write  <= cmd_write;
         s1_posted <= cmd_write_posted;
         s1_atomic <= cmd_atomic;
         s1_op     <= atomic_op;
      end
   end

   // stage 2, read the word and hand it to the ALU
   assign rd_data      = mem[s1_addr];
   assign alu_op       = s1_op;
   assign alu_old_data = rd_data;
   assign alu_operand  = s1_data;

   assign wr_en   = s1_valid & (s1_write | s1_atomic);
   assign wr_data = s1_atomic ? alu_new_data : s1_data;

   // posted writes update memory silently
   assign rsp_fire = s1_valid & ~s1_posted;

   // anything that is neither read, atomic nor write is unsupported
   always_comb begin
      rsp_opcode = UMI_RESP_ERROR;
      rsp_data   = '0;
      if (s1_read | s1_atomic) begin
         rsp_opcode = UMI_RESP_READ;
         rsp_data   = rd_data;
      end else if (s1_write) begin
         rsp_opcode = UMI_RESP_WRITE;
      end
   end

   // memory is cleared by reset, writes land in request order
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < DEPTH; i++) begin
            mem[i] <= '0;
         end
      end else if (wr_en) begin
         mem[s1_addr] <= wr_data;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         resp_valid <= 1'b0;
      end else begin
         resp_valid <= rsp_fire;
      end
   end

   // upper command bits come back as a tag
   always_ff @(posedge clk) begin
      if (rsp_fire) begin
         resp_cmd  <= {s1_cmd[CW-1:UMI_OPCODE_W], rsp_opcode};
         resp_addr <= s1_addr;
         resp_data <= rsp_data;
      end
   end

   // request classes from the decoder never overlap
   a_decode_onehot : assert property (@(posedge clk) disable iff (rst)
      req_valid |-> $onehot0({cmd_read, cmd_write & ~cmd_write_posted,
                              cmd_write_posted, cmd_atomic, cmd_unsupported}));

   // nothing left over in the pipe comes out after reset
   a_quiet_after_rst : assert property (@(posedge clk)
      rst |=> !resp_valid);

endmodule

`default_nettype wire

// File: umi_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module umi_mem_top
   import umi_pkg::*;
#(
   parameter int CW = 32,
   parameter int DW = 32,
   parameter int AW = 6
) (
   input  logic          clk,
   input  logic          rst,
   input  logic          req_valid,
   input  logic [CW-1:0] req_cmd,
   input  logic [AW-1:0] req_addr,
   input  logic [DW-1:0] req_data,
   output logic          resp_valid,
   output logic [CW-1:0] resp_cmd,
   output logic [AW-1:0] resp_addr,
   output logic [DW-1:0] resp_data
);

   logic          cmd_request;
   logic          cmd_read;
   logic          cmd_write;
   logic          cmd_write_posted;
   logic          cmd_atomic;
   logic          cmd_unsupported;
   umi_atomic_e   atomic_op;
   umi_atomic_e   alu_op;
   logic [DW-1:0] alu_old_data;
   logic [DW-1:0] alu_operand;
   logic [DW-1:0] alu_new_data;

   // invalid commands are already excluded by cmd_request
   umi_decode #(
      .CW (CW)
   ) u_decode (
      .command          (req_cmd),
      .cmd_invalid      (),
      .cmd_request      (cmd_request),
      .cmd_read         (cmd_read),
      .cmd_write        (cmd_write),
      .cmd_write_posted (cmd_write_posted),
      .cmd_atomic       (cmd_atomic),
      .cmd_unsupported  (cmd_unsupported),
      .atomic_op        (atomic_op)
   );

   umi_mem_endpoint #(
      .CW (CW),
      .DW (DW),
      .AW (AW)
   ) u_endpoint (
      .clk              (clk),
      .rst              (rst),
      .req_valid        (req_valid),
      .req_cmd          (req_cmd),
      .req_addr         (req_addr),
      .req_data         (req_data),
      .cmd_request      (cmd_request),
      .cmd_read         (cmd_read),
      .cmd_write        (cmd_write),
      .cmd_write_posted (cmd_write_posted),
      .cmd_atomic       (cmd_atomic),
      .cmd_unsupported  (cmd_unsupported),
      .atomic_op        (atomic_op),
      .alu_new_data     (alu_new_data),
      .alu_op           (alu_op),
      .alu_old_data     (alu_old_data),
      .alu_operand      (alu_operand),
      .resp_valid       (resp_valid),
      .resp_cmd         (resp_cmd),
      .resp_addr        (resp_addr),
      .resp_data        (resp_data)
   );

   umi_atomic_alu #(
      .DW (DW)
   ) u_alu (
      .op       (alu_op),
      .old_data (alu_old_data),
      .operand  (alu_operand),
      .new_data (alu_new_data)
   );

endmodule

`default_nettype wire

// File: tb_umi_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_umi_mem
   import umi_pkg::*;
();

   localparam int CW = 32;
   localparam int DW = 32;
   localparam int AW = 6;
   localparam int DEPTH = 1 << AW;
   localparam int N_RANDOM = 600;
   // directed part takes about 190 cycles, random part about 1350
   localparam int MAX_CYCLES = 3000;

   logic          clk;
   logic          rst;
   logic          req_valid;
   logic [CW-1:0] req_cmd;
   logic [AW-1:0] req_addr;
   logic [DW-1:0] req_data;
   logic          resp_valid;
   logic [CW-1:0] resp_cmd;
   logic [AW-1:0] resp_addr;
   logic [DW-1:0] resp_data;

   logic [DW-1:0] shadow [DEPTH];
   logic [31:0]   lfsr_state = 32'd72591;
   int            ncyc = 0;

   // expected responses, keyed by the falling edge they are due
   bit            exp_valid [int];
   logic [CW-1:0] exp_cmd [int];
   logic [AW-1:0] exp_addr [int];
   logic [DW-1:0] exp_data [int];

   umi_mem_top #(
      .CW (CW),
      .DW (DW),
      .AW (AW)
   ) u_umi_mem_top (
      .clk        (clk),
      .rst        (rst),
      .req_valid  (req_valid),
      .req_cmd    (req_cmd),
      .req_addr   (req_addr),
      .req_data   (req_data),
      .resp_valid (resp_valid),
      .resp_cmd   (resp_cmd),
      .resp_addr  (resp_addr),
      .resp_data  (resp_data)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // galois form of x^32 + x^22 + x^2 + x + 1
   function automatic void lfsr_step();
      if (lfsr_state[0]) begin
         lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
         lfsr_state = lfsr_state >> 1;
      end
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v = {v[30:0], lfsr_state[0]};
         lfsr_step();
      end
      return v;
   endfunction

   function automatic logic [DW-1:0] atomic_result(input logic [7:0] atype,
                                                   input logic [DW-1:0] old,
                                                   input logic [DW-1:0] opnd);
      case (atype)
         8'd0: return old + opnd;
         8'd1: return old & opnd;
         8'd2: return old | opnd;
         8'd3: return old ^ opnd;
         8'd4: return ($signed(opnd) > $signed(old)) ? opnd : old;
         8'd5: return ($signed(opnd) < $signed(old)) ? opnd : old;
         8'd6: return (opnd > old) ? opnd : old;
         8'd7: return (opnd < old) ? opnd : old;
         default: return opnd;
      endcase
   endfunction

   // applies one request to the shadow memory, returns 1 if a response is due
   function automatic bit model_request(input logic [CW-1:0] cmd,
                                        input logic [AW-1:0] addr,
                                        input logic [DW-1:0] data,
                                        output logic [CW-1:0] rcmd,
                                        output logic [DW-1:0] rdata);
      logic [7:0] opc;
      logic [7:0] atype;
      logic [7:0] rsp;
      opc = cmd[7:0];
      atype = cmd[15:8];
      rsp = UMI_RESP_ERROR;
      rcmd = '0;
      rdata = '0;
      // invalid and response opcodes are dropped
      if (opc == UMI_INVALID || opc[0]) begin
         return 1'b0;
      end
      if (opc == UMI_REQ_POSTED) begin
         shadow[addr] = data;
         return 1'b0;
      end
      if (opc == UMI_REQ_READ) begin
         rsp = UMI_RESP_READ;
         rdata = shadow[addr];
      end else if (opc == UMI_REQ_WRITE) begin
         rsp = UMI_RESP_WRITE;
         shadow[addr] = data;
      end else if (opc == UMI_REQ_ATOMIC && atype <= 8'd8) begin
         rsp = UMI_RESP_READ;
         rdata = shadow[addr];
         shadow[addr] = atomic_result(atype, shadow[addr], data);
      end
      rcmd = {cmd[CW-1:8], rsp};
      return 1'b1;
   endfunction

   task automatic report_mismatch(input string what, input logic [31:0] got,
                                  input logic [31:0] want);
      $display("MISMATCH at time %0t: %s is %h, expected %h", $time, what, got, want);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic abort_run(input string msg);
      $display("ERROR at time %0t: %s", $time, msg);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         req_valid <= 1'b0;
      end
   endtask

   task automatic send_req(input logic [CW-1:0] cmd, input logic [AW-1:0] addr,
                           input logic [DW-1:0] data);
      logic [CW-1:0] rcmd;
      logic [DW-1:0] rdata;
      int            due;
      @(posedge clk);
      req_valid <= 1'b1;
      req_cmd <= cmd;
      req_addr <= addr;
      req_data <= data;
      // sampled at the next rising edge, response visible two edges later
      due = ncyc + 3;
      if (model_request(cmd, addr, data, rcmd, rdata)) begin
         exp_valid[due] = 1'b1;
         exp_cmd[due] = rcmd;
         exp_addr[due] = addr;
         exp_data[due] = rdata;
      end
   endtask

   task automatic reset_read_test();
      int a;
      for (a = 0; a < DEPTH; a++) begin
         send_req({a[15:0], 8'h00, UMI_REQ_READ}, a[AW-1:0], 32'hFFFF_FFFF);
      end
      idle_cycles(3);
   endtask

   task automatic write_read_test();
      send_req({16'h0201, 8'h00, UMI_REQ_WRITE}, AW'(3), 32'hCAFE_0003);
      idle_cycles(2);
      send_req({16'h0202, 8'h00, UMI_REQ_READ}, AW'(3), 32'h0);
      send_req({16'h0203, 8'h00, UMI_REQ_POSTED}, AW'(9), 32'h1357_9BDF);
      idle_cycles(3);
      send_req({16'h0204, 8'h00, UMI_REQ_READ}, AW'(9), 32'h0);
      // consecutive cycles, each read must see the write just before it
      send_req({16'h0205, 8'h00, UMI_REQ_WRITE}, AW'(12), 32'h0BAD_F00D);
      send_req({16'h0206, 8'h00, UMI_REQ_READ}, AW'(12), 32'h0);
      send_req({16'h0207, 8'h00, UMI_REQ_POSTED}, AW'(12), 32'h7777_1111);
      send_req({16'h0208, 8'h00, UMI_REQ_READ}, AW'(12), 32'h0);
      idle_cycles(3);
   endtask

   task automatic atomic_test();
      logic [DW-1:0] olds [2];
      logic [DW-1:0] opnds [2];
      logic [AW-1:0] addr;
      int            r;
      int            t;
      // sign bits of old word and operand always differ
      olds = '{32'h8000_0005, 32'h0000_0007};
      opnds = '{32'h0000_0007, 32'hFFFF_FFF0};
      for (r = 0; r < 2; r++) begin
         for (t = 0; t < 9; t++) begin
            addr = AW'(20 + t);
            send_req({16'h0300, 8'h00, UMI_REQ_WRITE}, addr, olds[r]);
            send_req({r[7:0], 8'hA0, t[7:0], UMI_REQ_ATOMIC}, addr, opnds[r]);
            send_req({16'h0301, 8'h00, UMI_REQ_READ}, addr, '0);
            idle_cycles(1);
         end
      end
      idle_cycles(2);
   endtask

   task automatic error_test();
      logic [7:0] ops [12];
      logic [7:0] bad_types [3];
      int         i;
      ops = '{8'h00, 8'h01, 8'h03, 8'h0D, 8'h0F, 8'h37,
              8'h08, 8'h0C, 8'h0E, 8'h10, 8'h22, 8'hFE};
      bad_types = '{8'h09, 8'h80, 8'hFF};
      send_req({16'h0400, 8'h00, UMI_REQ_WRITE}, AW'(5), 32'h1234_5678);
      for (i = 0; i < 12; i++) begin
         send_req({16'h0401, 8'h00, ops[i]}, AW'(5), 32'hDEAD_BEEF);
      end
      for (i = 0; i < 3; i++) begin
         send_req({16'h0402, bad_types[i], UMI_REQ_ATOMIC}, AW'(5), 32'hDEAD_BEEF);
      end
      send_req({16'h0403, 8'h00, UMI_REQ_READ}, AW'(5), 32'h0);
      idle_cycles(3);
   endtask

   task automatic random_test();
      logic [31:0]   r;
      logic [31:0]   sel;
      logic [7:0]    opc;
      logic [7:0]    atype;
      logic [15:0]   tag;
      logic [AW-1:0] addr;
      logic [DW-1:0] data;
      int            n;
      for (n = 0; n < N_RANDOM; n++) begin
         sel = rand_bits(4);
         case (sel[3:0])
            4'd0, 4'd1, 4'd2, 4'd3: opc = UMI_REQ_READ;
            4'd4, 4'd5, 4'd6: opc = UMI_REQ_WRITE;
            4'd7, 4'd8: opc = UMI_REQ_POSTED;
            4'd9, 4'd10, 4'd11: opc = UMI_REQ_ATOMIC;
            4'd12: opc = UMI_REQ_RDMA;
            4'd13: opc = UMI_REQ_FUTURE0;
            4'd14: begin
               r = rand_bits(8);
               opc = r[7:0];
            end
            default: begin
               r = rand_bits(7);
               opc = {r[6:0], 1'b1};
            end
         endcase
         // types 9 to 15 are unknown
         r = rand_bits(4);
         atype = {4'h0, r[3:0]};
         r = rand_bits(16);
         tag = r[15:0];
         r = rand_bits(AW);
         addr = r[AW-1:0];
         data = rand_bits(DW);
         send_req({tag, atype, opc}, addr, data);
         // half the time the next request follows in the very next cycle
         r = rand_bits(2);
         if (r[1]) begin
            r = rand_bits(2);
            idle_cycles(r[1:0] + 1);
         end
      end
      idle_cycles(3);
   endtask

   initial begin
      rst = 1'b1;
      req_valid = 1'b0;
      req_cmd = '0;
      req_addr = '0;
      req_data = '0;
      shadow = '{default: '0};
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      idle_cycles(5);
      reset_read_test();
      write_read_test();
      atomic_test();
      error_test();
      random_test();
      idle_cycles(5);
      assert (exp_valid.num() == 0) begin
         $display("RESULT: PASS");
         $finish;
      end else begin
         abort_run("expected responses were never checked");
      end
   end

   // compare on falling edges where outputs are settled
   always @(negedge clk) begin
      ncyc = ncyc + 1;
      if (ncyc >= MAX_CYCLES) begin
         abort_run("timeout, cycle limit reached before the tests ended");
      end else if (!rst) begin
         if (exp_valid.exists(ncyc)) begin
            assert (resp_valid === 1'b1)
               else abort_run($sformatf("missing response due in cycle %0d", ncyc));
            assert (resp_cmd === exp_cmd[ncyc])
               else report_mismatch("resp_cmd", 32'(resp_cmd), 32'(exp_cmd[ncyc]));
            assert (resp_addr === exp_addr[ncyc])
               else report_mismatch("resp_addr", 32'(resp_addr), 32'(exp_addr[ncyc]));
            assert (resp_data === exp_data[ncyc])
               else report_mismatch("resp_data", 32'(resp_data), 32'(exp_data[ncyc]));
            exp_valid.delete(ncyc);
            exp_cmd.delete(ncyc);
            exp_addr.delete(ncyc);
            exp_data.delete(ncyc);
         end else begin
            assert (resp_valid === 1'b0)
               else abort_run("response seen without a matching request");
         end
      end
   end

endmodule

`default_nettype wire

// File: all.f
umi_pkg.sv
umi_decode.sv
umi_atomic_alu.sv
umi_mem_endpoint.sv
umi_mem_top.sv
tb_umi_mem.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps -j 0 \
   -f all.f --top-module tb_umi_mem -o sim_umi_mem

./obj_dir/sim_umi_mem 2>&1 | tee sim.log

if grep -q "RESULT: FAIL" sim.log; then
   echo "simulation failed"
   exit 1
fi

if ! grep -q "RESULT: PASS" sim.log; then
   echo "simulation ended without a result"
   exit 1
fi

echo "simulation passed"
